/* logic/exc_pkg.sv */
`default_nettype none

package exc_pkg;

    // machine word for pc, addresses and cp0 data
    typedef logic [31:0] word_t;

    // cause.exccode field
    typedef logic [4:0] exc_code_t;

    // cp0 register number from mtc0/mfc0
    typedef logic [4:0] cp0_addr_t;

    // one bit per interrupt line, ip7..ip0
    typedef logic [7:0] int_vec_t;

    // exception codes
    localparam exc_code_t CODE_INT  = 5'd0;
    localparam exc_code_t CODE_ADEL = 5'd4;
    localparam exc_code_t CODE_ADES = 5'd5;
    localparam exc_code_t CODE_SYS  = 5'd8;
    localparam exc_code_t CODE_BP   = 5'd9;
    localparam exc_code_t CODE_RI   = 5'd10;
    localparam exc_code_t CODE_OV   = 5'd12;

    // cp0 register numbers
    localparam cp0_addr_t CP0_BADVADDR = 5'd8;
    localparam cp0_addr_t CP0_COUNT    = 5'd9;
    localparam cp0_addr_t CP0_COMPARE  = 5'd11;
    localparam cp0_addr_t CP0_STATUS   = 5'd12;
    localparam cp0_addr_t CP0_CAUSE    = 5'd13;
    localparam cp0_addr_t CP0_EPC      = 5'd14;

    // status bit positions
    localparam int STATUS_IE  = 0;
    localparam int STATUS_EXL = 1;

    // software-writable fields: status im/exl/ie, cause ip1..0
    localparam word_t STATUS_WMASK = 32'h0000_ff03;
    localparam word_t CAUSE_WMASK  = 32'h0000_0300;

    // single general exception entry
    localparam word_t EXC_ENTRY = 32'hbfc0_0380;

endpackage

`default_nettype wire

/* logic/exception_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exception_unit (
    input  wire logic              reset,
    input  wire logic              commit_valid,
    input  wire exc_pkg::word_t    commit_pc,
    input  wire logic              in_delay_slot,
    input  wire logic              exc_instr_addr,
    input  wire logic              exc_ri,
    input  wire logic              exc_ov,
    input  wire logic              exc_sys,
    input  wire logic              exc_bp,
    input  wire logic              exc_load_addr,
    input  wire logic              exc_store_addr,
    input  wire exc_pkg::word_t    bad_vaddr,
    input  wire logic              eret,
    input  wire exc_pkg::int_vec_t interrupt_pending,
    input  wire logic              int_enable,
    input  wire logic              squash,
    output logic                   exc_taken,
    output exc_pkg::exc_code_t     exc_code,
    output exc_pkg::word_t         exc_pc,
    output logic                   exc_bd,
    output logic                   exc_badvaddr_we,
    output exc_pkg::word_t         exc_badvaddr,
    output logic                   eret_taken
);

    import exc_pkg::*;

    logic      event_ok;
    logic      int_valid;
    logic      any_exc;
    logic      addr_err;
    exc_code_t code;
    word_t     vaddr_sel;

    // a commit only counts outside reset and outside the squash slot
    assign event_ok  = commit_valid & ~squash & ~reset;
    assign int_valid = (interrupt_pending != '0) & int_enable;

    // fixed priority, interrupt first
    always_comb begin
        any_exc   = 1'b1;
        addr_err  = 1'b0;
        vaddr_sel = bad_vaddr;
        code      = CODE_INT;
        if (int_valid) begin
            code = CODE_INT;
        end else if (exc_instr_addr) begin
            code      = CODE_ADEL;
            addr_err  = 1'b1;
            vaddr_sel = commit_pc;
        end else if (exc_ri) begin
            code = CODE_RI;
        end else if (exc_ov) begin
            code = CODE_OV;
        end else if (exc_sys) begin
            code = CODE_SYS;
        end else if (exc_bp) begin
            code = CODE_BP;
        end else if (exc_load_addr) begin
            code     = CODE_ADEL;
            addr_err = 1'b1;
        end else if (exc_store_addr) begin
            code     = CODE_ADES;
            addr_err = 1'b1;
        end else begin
            any_exc = 1'b0;
        end
    end

    assign exc_taken       = event_ok & any_exc;
    assign exc_code        = code;
    assign exc_pc          = commit_pc;
    assign exc_bd          = in_delay_slot;
    assign exc_badvaddr_we = exc_taken & addr_err;
    assign exc_badvaddr    = vaddr_sel;

    // eret loses to any exception on the same commit
    assign eret_taken = event_ok & eret & ~any_exc;

endmodule

`default_nettype wire

/* logic/cp0_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0_regs (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               exc_taken,
    input  wire exc_pkg::exc_code_t exc_code,
    input  wire exc_pkg::word_t     exc_pc,
    input  wire logic               exc_bd,
    input  wire logic               exc_badvaddr_we,
    input  wire exc_pkg::word_t     exc_badvaddr,
    input  wire logic               eret_taken,
    input  wire logic [5:0]         hw_int,
    input  wire logic               cp0_we,
    input  wire exc_pkg::cp0_addr_t cp0_addr,
    input  wire exc_pkg::word_t     cp0_wdata,
    output exc_pkg::word_t          cp0_rdata,
    output exc_pkg::int_vec_t       interrupt_pending,
    output logic                    int_enable,
    output exc_pkg::word_t          epc
);

    import exc_pkg::*;

    word_t     status_q;
    word_t     count_q;
    word_t     compare_q;
    word_t     epc_q;
    word_t     badvaddr_q;
    logic      cause_bd_q;
    exc_code_t cause_code_q;
    logic [1:0] sw_ip_q;
    logic [5:0] hw_ip_q;
    logic      timer_irq_q;
    int_vec_t  ip;
    word_t     cause;

    logic wr_status;
    logic wr_cause;
    logic wr_count;
    logic wr_compare;
    logic wr_epc;

    assign wr_status  = cp0_we & (cp0_addr == CP0_STATUS);
    assign wr_cause   = cp0_we & (cp0_addr == CP0_CAUSE);
    assign wr_count   = cp0_we & (cp0_addr == CP0_COUNT);
    assign wr_compare = cp0_we & (cp0_addr == CP0_COMPARE);
    assign wr_epc     = cp0_we & (cp0_addr == CP0_EPC);

    // exl from the event wins over an mtc0 in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            status_q <= '0;
        end else begin
            if (wr_status) begin
                status_q <= (status_q & ~STATUS_WMASK) | (cp0_wdata & STATUS_WMASK);
            end
            if (exc_taken) begin
                status_q[STATUS_EXL] <= 1'b1;
            end else if (eret_taken) begin
                status_q[STATUS_EXL] <= 1'b0;
            end
        end
    end

    // cause fields, timer and sampled hardware lines
    always_ff @(posedge clk) begin
        if (reset) begin
            cause_bd_q   <= 1'b0;
            cause_code_q <= '0;
            sw_ip_q      <= '0;
            hw_ip_q      <= '0;
            timer_irq_q  <= 1'b0;
            count_q      <= '0;
            compare_q    <= '1;
        end else begin
            hw_ip_q <= hw_int;
            if (wr_cause) begin
                sw_ip_q <= cp0_wdata[9:8];
            end
            if (exc_taken) begin
                cause_bd_q   <= exc_bd;
                cause_code_q <= exc_code;
            end
            if (wr_count) begin
                count_q <= cp0_wdata;
            end else begin
                count_q <= count_q + 32'd1;
            end
            // a compare write acknowledges the timer
            if (wr_compare) begin
                compare_q   <= cp0_wdata;
                timer_irq_q <= 1'b0;
            end else if (count_q == compare_q) begin
                timer_irq_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exc_taken) begin
            epc_q <= exc_bd ? exc_pc - 32'd4 : exc_pc;
        end else if (wr_epc) begin
            epc_q <= cp0_wdata;
        end
        if (exc_badvaddr_we) begin
            badvaddr_q <= exc_badvaddr;
        end
    end

    // timer shares ip7 with the top hardware line
    assign ip    = {timer_irq_q | hw_ip_q[5], hw_ip_q[4:0], sw_ip_q};
    assign cause = {cause_bd_q, 15'b0, ip, 1'b0, cause_code_q, 2'b0};

    assign interrupt_pending = ip & status_q[15:8];
    assign int_enable        = status_q[STATUS_IE] & ~status_q[STATUS_EXL];
    assign epc               = epc_q;

    always_comb begin
        case (cp0_addr)
            CP0_BADVADDR: cp0_rdata = badvaddr_q;
            CP0_COUNT:    cp0_rdata = count_q;
            CP0_COMPARE:  cp0_rdata = compare_q;
            CP0_STATUS:   cp0_rdata = status_q;
            CP0_CAUSE:    cp0_rdata = cause;
            CP0_EPC:      cp0_rdata = epc_q;
            default:      cp0_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/pc_redirect.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_redirect #(
    parameter exc_pkg::word_t EXC_ENTRY_ADDR = exc_pkg::EXC_ENTRY
) (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           exc_taken,
    input  wire logic           eret_taken,
    input  wire exc_pkg::word_t epc,
    output logic                redirect_valid,
    output exc_pkg::word_t      redirect_pc,
    output logic                squash
);

    logic event_taken;

    assign event_taken = exc_taken | eret_taken;

    // one-cycle pulse after each taken event
    always_ff @(posedge clk) begin
        if (reset) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= event_taken;
        end
    end

    // target captured in the event cycle, epc before its update
    always_ff @(posedge clk) begin
        if (exc_taken) begin
            redirect_pc <= EXC_ENTRY_ADDR;
        end else if (eret_taken) begin
            redirect_pc <= epc;
        end
    end

    // the commit slot during the redirect is wrong-path
    assign squash = redirect_valid;

endmodule

`default_nettype wire

/* logic/exc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exc_top #(
    parameter exc_pkg::word_t EXC_ENTRY_ADDR = exc_pkg::EXC_ENTRY
) (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               commit_valid,
    input  wire exc_pkg::word_t     commit_pc,
    input  wire logic               in_delay_slot,
    input  wire logic               exc_instr_addr,
    input  wire logic               exc_ri,
    input  wire logic               exc_ov,
    input  wire logic               exc_sys,
    input  wire logic               exc_bp,
    input  wire logic               exc_load_addr,
    input  wire logic               exc_store_addr,
    input  wire exc_pkg::word_t     bad_vaddr,
    input  wire logic               eret,
    input  wire logic [5:0]         hw_int,
    input  wire logic               cp0_we,
    input  wire exc_pkg::cp0_addr_t cp0_addr,
    input  wire exc_pkg::word_t     cp0_wdata,
    output exc_pkg::word_t          cp0_rdata,
    output logic                    redirect_valid,
    output exc_pkg::word_t          redirect_pc
);

    import exc_pkg::*;

    logic      exc_taken;
    exc_code_t exc_code;
    word_t     exc_pc;
    logic      exc_bd;
    logic      exc_badvaddr_we;
    word_t     exc_badvaddr;
    logic      eret_taken;
    int_vec_t  interrupt_pending;
    logic      int_enable;
    word_t     epc;
    logic      squash;

    exception_unit i_exception_unit (
        .reset             (reset),
        .commit_valid      (commit_valid),
        .commit_pc         (commit_pc),
        .in_delay_slot     (in_delay_slot),
        .exc_instr_addr    (exc_instr_addr),
        .exc_ri            (exc_ri),
        .exc_ov            (exc_ov),
        .exc_sys           (exc_sys),
        .exc_bp            (exc_bp),
        .exc_load_addr     (exc_load_addr),
        .exc_store_addr    (exc_store_addr),
        .bad_vaddr         (bad_vaddr),
        .eret              (eret),
        .interrupt_pending (interrupt_pending),
        .int_enable        (int_enable),
        .squash            (squash),
        .exc_taken         (exc_taken),
        .exc_code          (exc_code),
        .exc_pc            (exc_pc),
        .exc_bd            (exc_bd),
        .exc_badvaddr_we   (exc_badvaddr_we),
        .exc_badvaddr      (exc_badvaddr),
        .eret_taken        (eret_taken)
    );

    cp0_regs i_cp0_regs (
        .clk               (clk),
        .reset             (reset),
        .exc_taken         (exc_taken),
        .exc_code          (exc_code),
        .exc_pc            (exc_pc),
        .exc_bd            (exc_bd),
        .exc_badvaddr_we   (exc_badvaddr_we),
        .exc_badvaddr      (exc_badvaddr),
        .eret_taken        (eret_taken),
        .hw_int            (hw_int),
        .cp0_we            (cp0_we),
        .cp0_addr          (cp0_addr),
        .cp0_wdata         (cp0_wdata),
        .cp0_rdata         (cp0_rdata),
        .interrupt_pending (interrupt_pending),
        .int_enable        (int_enable),
        .epc               (epc)
    );

    pc_redirect #(
        .EXC_ENTRY_ADDR (EXC_ENTRY_ADDR)
    ) i_pc_redirect (
        .clk            (clk),
        .reset          (reset),
        .exc_taken      (exc_taken),
        .eret_taken     (eret_taken),
        .epc            (epc),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .squash         (squash)
    );

endmodule

`default_nettype wire

/* verif/exc_props.sv */
`timescale 1ns/1ps
`default_nettype none

module exc_props #(
    parameter exc_pkg::word_t ENTRY_ADDR = exc_pkg::EXC_ENTRY
) (
    input wire logic           clk,
    input wire logic           reset,
    input wire logic           redirect_valid,
    input wire exc_pkg::word_t redirect_pc,
    input wire exc_pkg::word_t epc
);

    // redirect is a one-cycle pulse
    redirect_single: assert property (
        @(posedge clk) disable iff (reset) redirect_valid |=> !redirect_valid
    ) else $error("redirect_valid high for two cycles in a row");

    // quiet after every reset edge, so also the first cycle out of reset
    redirect_reset: assert property (
        @(posedge clk) reset |=> !redirect_valid
    ) else $error("redirect_valid high during or right after reset");

    redirect_target: assert property (
        @(posedge clk) disable iff (reset)
        redirect_valid |-> (redirect_pc == ENTRY_ADDR || redirect_pc == epc)
    ) else $error("redirect_pc is neither the exception entry nor epc");

endmodule

bind exc_top exc_props #(
    .ENTRY_ADDR (EXC_ENTRY_ADDR)
) i_exc_props (
    .clk            (clk),
    .reset          (reset),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .epc            (epc)
);

`default_nettype wire

/* verif/exc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exc_tb;

    import exc_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int SEED       = 55058;
    localparam int N_PRIO     = 40;
    // reset, reset reads, priority loop, masking, timer, squash
    localparam int TEST_CYCLES = 2 + 4 + N_PRIO * 6 + 25 + 40 + 10;

    logic       clk;
    logic       reset;
    logic       commit_valid;
    word_t      commit_pc;
    logic       in_delay_slot;
    logic       exc_instr_addr;
    logic       exc_ri;
    logic       exc_ov;
    logic       exc_sys;
    logic       exc_bp;
    logic       exc_load_addr;
    logic       exc_store_addr;
    word_t      bad_vaddr;
    logic       eret;
    logic [5:0] hw_int;
    logic       cp0_we;
    cp0_addr_t  cp0_addr;
    word_t      cp0_wdata;
    word_t      cp0_rdata;
    logic       redirect_valid;
    word_t      redirect_pc;

    // reference model state
    logic       m_ie;
    logic       m_exl;
    logic [7:0] m_im;
    logic       m_bd;
    exc_code_t  m_code;
    logic [1:0] m_sw_ip;
    logic [5:0] m_hw_q;
    logic       m_timer;
    word_t      m_count;
    word_t      m_compare;
    word_t      m_epc;
    word_t      m_badvaddr;
    logic       m_rv;
    word_t      m_rpc;

    int_vec_t   m_ip;
    logic       m_int;
    logic       m_commit;
    logic       m_exc;
    exc_code_t  m_next_code;
    logic       m_bv_we;
    word_t      m_bv;
    word_t      exp_rdata;

    word_t      rnd;
    logic [6:0] flags;
    word_t      pc;
    word_t      vaddr;

    exc_top i_dut (
        .clk            (clk),
        .reset          (reset),
        .commit_valid   (commit_valid),
        .commit_pc      (commit_pc),
        .in_delay_slot  (in_delay_slot),
        .exc_instr_addr (exc_instr_addr),
        .exc_ri         (exc_ri),
        .exc_ov         (exc_ov),
        .exc_sys        (exc_sys),
        .exc_bp         (exc_bp),
        .exc_load_addr  (exc_load_addr),
        .exc_store_addr (exc_store_addr),
        .bad_vaddr      (bad_vaddr),
        .eret           (eret),
        .hw_int         (hw_int),
        .cp0_we         (cp0_we),
        .cp0_addr       (cp0_addr),
        .cp0_wdata      (cp0_wdata),
        .cp0_rdata      (cp0_rdata),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // which event the committing instruction raises in the model
    always_comb begin
        m_ip        = {m_timer | m_hw_q[5], m_hw_q[4:0], m_sw_ip};
        m_int       = ((m_ip & m_im) != 8'h00) && m_ie && !m_exl;
        m_commit    = commit_valid && !m_rv && !reset;
        m_exc       = 1'b1;
        m_bv_we     = 1'b0;
        m_bv        = bad_vaddr;
        m_next_code = CODE_INT;
        casez ({m_int, exc_instr_addr, exc_ri, exc_ov, exc_sys, exc_bp,
                exc_load_addr, exc_store_addr})
            8'b1???????: m_next_code = CODE_INT;
            8'b01??????: begin
                m_next_code = CODE_ADEL;
                m_bv_we     = 1'b1;
                m_bv        = commit_pc;
            end
            8'b001?????: m_next_code = CODE_RI;
            8'b0001????: m_next_code = CODE_OV;
            8'b00001???: m_next_code = CODE_SYS;
            8'b000001??: m_next_code = CODE_BP;
            8'b0000001?: begin
                m_next_code = CODE_ADEL;
                m_bv_we     = 1'b1;
            end
            8'b00000001: begin
                m_next_code = CODE_ADES;
                m_bv_we     = 1'b1;
            end
            default: m_exc = 1'b0;
        endcase
    end

    // expected mfc0 data
    always_comb begin
        case (cp0_addr)
            CP0_BADVADDR: exp_rdata = m_badvaddr;
            CP0_COUNT:    exp_rdata = m_count;
            CP0_COMPARE:  exp_rdata = m_compare;
            CP0_STATUS:   exp_rdata = {16'b0, m_im, 6'b0, m_exl, m_ie};
            CP0_CAUSE:    exp_rdata = {m_bd, 15'b0, m_ip, 1'b0, m_code, 2'b0};
            CP0_EPC:      exp_rdata = m_epc;
            default:      exp_rdata = '0;
        endcase
    end

    always @(posedge clk) begin
        if (reset) begin
            m_ie      <= 1'b0;
            m_exl     <= 1'b0;
            m_im      <= '0;
            m_bd      <= 1'b0;
            m_code    <= '0;
            m_sw_ip   <= '0;
            m_hw_q    <= '0;
            m_timer   <= 1'b0;
            m_count   <= '0;
            m_compare <= '1;
            m_rv      <= 1'b0;
        end else begin
            m_hw_q <= hw_int;
            if (cp0_we && cp0_addr == CP0_COUNT) begin
                m_count <= cp0_wdata;
            end else begin
                m_count <= m_count + 32'd1;
            end
            if (cp0_we && cp0_addr == CP0_COMPARE) begin
                m_compare <= cp0_wdata;
                m_timer   <= 1'b0;
            end else if (m_count == m_compare) begin
                m_timer <= 1'b1;
            end
            if (cp0_we && cp0_addr == CP0_STATUS) begin
                m_ie  <= cp0_wdata[0];
                m_exl <= cp0_wdata[1];
                m_im  <= cp0_wdata[15:8];
            end
            if (cp0_we && cp0_addr == CP0_CAUSE) begin
                m_sw_ip <= cp0_wdata[9:8];
            end
            if (cp0_we && cp0_addr == CP0_EPC) begin
                m_epc <= cp0_wdata;
            end
            // the event overrides an mtc0 of the same cycle
            if (m_commit && m_exc) begin
                m_exl  <= 1'b1;
                m_bd   <= in_delay_slot;
                m_code <= m_next_code;
                m_epc  <= in_delay_slot ? commit_pc - 32'd4 : commit_pc;
                m_rpc  <= EXC_ENTRY;
                if (m_bv_we) begin
                    m_badvaddr <= m_bv;
                end
            end else if (m_commit && eret) begin
                m_exl <= 1'b0;
                m_rpc <= m_epc;
            end
            m_rv <= m_commit && (m_exc || eret);
        end
    end

    task automatic report_mismatch(input string name, input word_t expected,
                                   input word_t actual);
        $display("Fail t=%0t %s expected %h actual %h", $time, name, expected, actual);
        $display("ERRORS FOUND");
        $fatal(1, "check on %s failed", name);
    endtask

    rdata_check: assert property (@(posedge clk) disable iff (reset)
        cp0_rdata == exp_rdata)
        else report_mismatch("cp0_rdata", $sampled(exp_rdata), $sampled(cp0_rdata));

    valid_check: assert property (@(posedge clk) disable iff (reset)
        redirect_valid == m_rv)
        else report_mismatch("redirect_valid", {31'b0, $sampled(m_rv)},
                             {31'b0, $sampled(redirect_valid)});

    target_check: assert property (@(posedge clk) disable iff (reset)
        redirect_valid |-> redirect_pc == m_rpc)
        else report_mismatch("redirect_pc", $sampled(m_rpc), $sampled(redirect_pc));

    // flags from instr_addr down to store in priority order
    task automatic set_flags(input logic [6:0] f);
        {exc_instr_addr, exc_ri, exc_ov, exc_sys, exc_bp, exc_load_addr,
         exc_store_addr} = f;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            commit_valid = 1'b0;
            eret         = 1'b0;
            cp0_we       = 1'b0;
            set_flags(7'b0);
        end
    endtask

    task automatic commit_instr(input logic [6:0] f, input logic is_eret,
                                input word_t ipc, input logic ds, input word_t va);
        @(posedge clk);
        #1;
        commit_valid  = 1'b1;
        eret          = is_eret;
        commit_pc     = ipc;
        in_delay_slot = ds;
        bad_vaddr     = va;
        cp0_we        = 1'b0;
        set_flags(f);
    endtask

    task automatic write_cp0(input cp0_addr_t addr, input word_t data);
        @(posedge clk);
        #1;
        commit_valid = 1'b0;
        eret         = 1'b0;
        cp0_we       = 1'b1;
        cp0_addr     = addr;
        cp0_wdata    = data;
        set_flags(7'b0);
    endtask

    initial begin
        #(TEST_CYCLES * CLK_PERIOD + 100 * CLK_PERIOD);
        $display("watchdog timeout, the tests did not finish in time");
        $display("ERRORS FOUND");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        commit_valid  = 1'b0;
        commit_pc     = '0;
        in_delay_slot = 1'b0;
        bad_vaddr     = '0;
        eret          = 1'b0;
        hw_int        = '0;
        cp0_we        = 1'b0;
        cp0_addr      = CP0_STATUS;
        cp0_wdata     = '0;
        set_flags(7'b0);
        void'($urandom(SEED));
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // reset values
        idle_cycles(2);
        cp0_addr = CP0_CAUSE;
        idle_cycles(2);

        // priority, epc, bd and badvaddr; first pass is a load error
        for (int i = 0; i < N_PRIO; i++) begin
            rnd   = $urandom;
            flags = (i == 0) ? 7'b0000010 : rnd[6:0];
            if (flags == 7'b0) begin
                flags = 7'b0001000;
            end
            pc    = $urandom & 32'hffff_fffc;
            vaddr = $urandom;
            cp0_addr = CP0_CAUSE;
            commit_instr(flags, 1'b0, pc, rnd[8], vaddr);
            idle_cycles(1);
            cp0_addr = CP0_EPC;
            idle_cycles(1);
            cp0_addr = CP0_BADVADDR;
            idle_cycles(1);
            commit_instr(7'b0, 1'b1, pc + 32'h40, 1'b0, vaddr);
            idle_cycles(1);
        end

        // interrupt masking by ie and exl
        write_cp0(CP0_STATUS, 32'h0000_ff00);
        hw_int = 6'b000001;
        idle_cycles(2);
        commit_instr(7'b0, 1'b0, 32'h0000_1000, 1'b0, '0);
        idle_cycles(1);
        commit_instr(7'b0001000, 1'b0, 32'h0000_1004, 1'b0, '0);
        idle_cycles(1);
        write_cp0(CP0_STATUS, 32'h0000_ff03);
        commit_instr(7'b0, 1'b0, 32'h0000_2000, 1'b0, '0);
        idle_cycles(1);
        cp0_addr = CP0_CAUSE;
        commit_instr(7'b0, 1'b1, 32'h0000_2004, 1'b0, '0);
        idle_cycles(1);
        commit_instr(7'b0, 1'b0, 32'h0000_1008, 1'b0, '0);
        idle_cycles(1);
        hw_int = 6'b0;
        idle_cycles(2);
        commit_instr(7'b0, 1'b1, 32'h0000_2008, 1'b0, '0);
        idle_cycles(1);

        // timer interrupt
        write_cp0(CP0_COUNT, 32'd0);
        write_cp0(CP0_COMPARE, 32'd20);
        idle_cycles(1);
        cp0_addr = CP0_CAUSE;
        idle_cycles(23);
        commit_instr(7'b0, 1'b0, 32'h0000_3000, 1'b0, '0);
        idle_cycles(1);
        write_cp0(CP0_COMPARE, 32'hffff_ffff);
        idle_cycles(1);
        cp0_addr = CP0_CAUSE;
        commit_instr(7'b0, 1'b1, 32'h0000_3004, 1'b0, '0);
        idle_cycles(1);

        // wrong-path commit during the redirect cycle
        commit_instr(7'b0010000, 1'b0, 32'h0000_4000, 1'b0, '0);
        commit_instr(7'b0100001, 1'b1, 32'h0000_5000, 1'b1, 32'h0000_5555);
        idle_cycles(1);
        cp0_addr = CP0_EPC;
        idle_cycles(1);
        commit_instr(7'b0, 1'b1, 32'h0000_4004, 1'b0, '0);
        idle_cycles(2);

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
logic/exc_pkg.sv
logic/exception_unit.sv
logic/cp0_regs.sv
logic/pc_redirect.sv
logic/exc_top.sv
verif/exc_props.sv
verif/exc_tb.sv

/* Makefile */
TOP = exc_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timing -f all.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "NO ERRORS"

clean:
	rm -rf obj_dir
